// ==== soc_config.svh ====
`ifndef SOC_CONFIG_SVH
`define SOC_CONFIG_SVH

// program memory
`define RAM_DEPTH 64
`define RAM_AW 6 // log2 of RAM_DEPTH

// register file
`define NUM_REGS 32

// character log buffer, power of two
`define FIFO_DEPTH 16

// uart bit time in clocks, 868 for 115200 baud at 100 MHz
`define CLK_PER_BIT 16

`endif

// ==== cpu_pkg.sv ====
`include "soc_config.svh"

package cpu_pkg;

  // first byte of the first instruction word
  typedef enum logic [7:0] {
    OP_JMP     = 8'd1,  // pc <= operand
    OP_RAM2REG = 8'd2,  // reg <= ram[operand]
    OP_REG2RAM = 8'd3,  // ram[operand] <= reg
    OP_NUM2REG = 8'd4,  // reg <= operand
    OP_OUT     = 8'd15  // log low byte of reg
  } opcode_e;

  // first instruction word, second word is the plain operand
  typedef struct packed {
    opcode_e    opcode;
    logic [7:0] reg_idx;
  } instr_hi_t;

  // one write into program ram
  typedef struct packed {
    logic              en;
    logic [`RAM_AW-1:0] addr;
    logic [15:0]       data;
  } ram_wr_t;

  typedef enum logic [2:0] {
    CS_IDLE,
    CS_FETCH_HI,  // read of pc issued
    CS_FETCH_LO,  // read of pc+1 issued
    CS_MEM,       // operand present, execute
    CS_LOG        // push character, step pc
  } core_state_e;

endpackage

// ==== uart_pkg.sv ====
package uart_pkg;

  // one character towards the log fifo
  typedef struct packed {
    logic       push;  // single cycle strobe
    logic [7:0] data;
  } log_byte_t;

  typedef enum logic [1:0] {
    TX_IDLE,
    TX_START,
    TX_DATA,
    TX_STOP
  } tx_state_e;

  // logged when a run starts
  localparam logic [7:0] CHAR_START = "S";

  // logged for an opcode the core does not know
  localparam logic [7:0] CHAR_BAD = "x";

endpackage

// ==== program_ram.sv ====
`timescale 1ns/10ps
`include "soc_config.svh"

module program_ram import cpu_pkg::*; (
  input  logic               clk,
  input  ram_wr_t            load,
  input  ram_wr_t            core_wr,
  input  logic [`RAM_AW-1:0] rd_addr,
  output logic [15:0]        rd_data
);

  logic [15:0] mem [`RAM_DEPTH];
  ram_wr_t     wr;

  // loader wins over the core
  assign wr = load.en ? load : core_wr;

  always_ff @(posedge clk) begin
    if (wr.en) begin
      mem[wr.addr] <= wr.data;
    end
    rd_data <= mem[rd_addr];  // one cycle read latency
  end

endmodule

// ==== cpu_core.sv ====
`timescale 1ns/10ps
`include "soc_config.svh"

module cpu_core import cpu_pkg::*, uart_pkg::*; (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               run,
  output logic [`RAM_AW-1:0] rd_addr,
  input  logic [15:0]        rd_data,
  output ram_wr_t            core_wr,
  output log_byte_t          log_in,
  input  logic               log_full
);

  localparam int REG_AW = $clog2(`NUM_REGS);
  localparam logic [`RAM_AW-1:0] PC_STEP = 2;  // two words per instruction

  core_state_e        state;
  logic [`RAM_AW-1:0] pc;
  logic               mem_rd;   // second MEM cycle of RAM2REG
  instr_hi_t          instr;
  logic [15:0]        operand;
  logic [15:0]        regs [`NUM_REGS];
  logic [REG_AW-1:0]  ridx;
  logic [15:0]        reg_val;
  logic [7:0]         log_char;

  assign ridx    = instr.reg_idx[REG_AW-1:0];  // upper index bits ignored
  assign reg_val = regs[ridx];

  // ram read address follows the state
  always_comb begin
    case (state)
      CS_FETCH_LO: rd_addr = pc + 1'b1;
      CS_MEM:      rd_addr = rd_data[`RAM_AW-1:0];  // data address for RAM2REG
      default:     rd_addr = pc;
    endcase
  end

  // REG2RAM stores in the first MEM cycle
  always_comb begin
    core_wr.en   = (state == CS_MEM) && !mem_rd && (instr.opcode == OP_REG2RAM);
    core_wr.addr = rd_data[`RAM_AW-1:0];
    core_wr.data = reg_val;
  end

  always_comb begin
    case (instr.opcode)
      OP_JMP:     log_char = "1";
      OP_RAM2REG: log_char = "2";
      OP_REG2RAM: log_char = "3";
      OP_NUM2REG: log_char = "4";
      OP_OUT:     log_char = reg_val[7:0];
      default:    log_char = CHAR_BAD;
    endcase
  end

  // 'S' at run start, else the instruction character
  always_comb begin
    log_in.push = !log_full && ((state == CS_IDLE && run) || state == CS_LOG);
    log_in.data = (state == CS_IDLE) ? CHAR_START : log_char;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state  <= CS_IDLE;
      pc     <= '0;
      mem_rd <= 1'b0;
    end else begin
      case (state)
        CS_IDLE: begin
          if (run && !log_full) begin
            pc    <= '0;
            state <= CS_FETCH_HI;
          end
        end
        CS_FETCH_HI: state <= CS_FETCH_LO;
        CS_FETCH_LO: state <= CS_MEM;
        CS_MEM: begin
          if (!mem_rd && instr.opcode == OP_RAM2REG) begin
            mem_rd <= 1'b1;  // wait for the data word
          end else begin
            mem_rd <= 1'b0;
            state  <= CS_LOG;
          end
        end
        CS_LOG: begin
          if (!log_full) begin  // hold here under back-pressure
            if (instr.opcode == OP_JMP) begin
              pc <= operand[`RAM_AW-1:0];
            end else begin
              pc <= pc + PC_STEP;
            end
            state <= run ? CS_FETCH_HI : CS_IDLE;
          end
        end
        default: state <= CS_IDLE;
      endcase
    end
  end

  // instruction and operand latches
  always_ff @(posedge clk) begin
    if (state == CS_FETCH_LO) begin
      instr <= instr_hi_t'(rd_data);
    end
    if (state == CS_MEM && !mem_rd) begin
      operand <= rd_data;
    end
  end

  // NUM2REG takes the operand, RAM2REG the word read one cycle later
  always_ff @(posedge clk) begin
    if (state == CS_MEM && (mem_rd || instr.opcode == OP_NUM2REG)) begin
      regs[ridx] <= rd_data;
    end
  end

endmodule

// ==== log_fifo.sv ====
`timescale 1ns/10ps
`include "soc_config.svh"

module log_fifo import uart_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  log_byte_t  log_in,
  input  logic       pop,
  output logic [7:0] log_data,
  output logic       log_empty,
  output logic       log_full
);

  localparam int PW = $clog2(`FIFO_DEPTH);

  logic [7:0]    mem [`FIFO_DEPTH];
  logic [PW-1:0] wr_ptr;
  logic [PW-1:0] rd_ptr;
  logic [PW:0]   count;
  logic          do_push;
  logic          do_pop;

  assign do_push   = log_in.push && !log_full;
  assign do_pop    = pop && !log_empty;
  assign log_empty = (count == '0);
  assign log_full  = (count == (PW + 1)'(`FIFO_DEPTH));
  assign log_data  = mem[rd_ptr];  // head always visible

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1;  // wraps at depth
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= log_in.data;
    end
  end

endmodule

// ==== uart_tx.sv ====
`timescale 1ns/10ps
`include "soc_config.svh"

module uart_tx import uart_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       log_empty,
  input  logic [7:0] log_data,
  output logic       pop,
  output logic       tx
);

  localparam int CW = $clog2(`CLK_PER_BIT);
  localparam logic [CW-1:0] CNT_LOAD = CW'(`CLK_PER_BIT - 1);

  tx_state_e     state;
  logic [CW-1:0] cnt;       // cycles left in this bit
  logic [2:0]    bit_idx;
  logic [7:0]    shreg;     // data bits still to send
  logic          bit_done;

  assign pop      = (state == TX_IDLE) && !log_empty;
  assign bit_done = (cnt == '0);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state   <= TX_IDLE;
      cnt     <= '0;
      bit_idx <= '0;
      tx      <= 1'b1;  // line idles high
    end else begin
      case (state)
        TX_IDLE: begin
          if (pop) begin
            tx    <= 1'b0;  // start bit
            cnt   <= CNT_LOAD;
            state <= TX_START;
          end
        end
        TX_START: begin
          cnt <= bit_done ? CNT_LOAD : cnt - 1'b1;
          if (bit_done) begin
            tx      <= shreg[0];  // lsb first
            bit_idx <= '0;
            state   <= TX_DATA;
          end
        end
        TX_DATA: begin
          cnt <= bit_done ? CNT_LOAD : cnt - 1'b1;
          if (bit_done) begin
            if (bit_idx == 3'd7) begin
              tx    <= 1'b1;  // stop bit
              state <= TX_STOP;
            end else begin
              tx      <= shreg[0];
              bit_idx <= bit_idx + 1'b1;
            end
          end
        end
        TX_STOP: begin
          cnt <= cnt - 1'b1;
          if (bit_done) begin
            state <= TX_IDLE;
          end
        end
        default: state <= TX_IDLE;
      endcase
    end
  end

  // byte taken at the pop, shifted as bits go out
  always_ff @(posedge clk) begin
    if (pop) begin
      shreg <= log_data;
    end else if (bit_done && (state == TX_START || state == TX_DATA)) begin
      shreg <= shreg >> 1;
    end
  end

endmodule

// ==== cpu_top.sv ====
`timescale 1ns/10ps
`include "soc_config.svh"

module cpu_top import cpu_pkg::*, uart_pkg::*; (
  input  logic    clk,
  input  logic    rst_n,
  input  logic    run,
  input  ram_wr_t load,  // program load, only while run is low
  output logic    tx
);

  ram_wr_t            core_wr;
  logic [`RAM_AW-1:0] rd_addr;
  logic [15:0]        rd_data;
  log_byte_t          log_in;
  logic               log_full;
  logic               log_empty;
  logic [7:0]         log_data;
  logic               pop;

  program_ram u_ram (
    .clk     (clk),
    .load    (load),
    .core_wr (core_wr),
    .rd_addr (rd_addr),
    .rd_data (rd_data)
  );

  cpu_core u_core (
    .clk      (clk),
    .rst_n    (rst_n),
    .run      (run),
    .rd_addr  (rd_addr),
    .rd_data  (rd_data),
    .core_wr  (core_wr),
    .log_in   (log_in),
    .log_full (log_full)
  );

  log_fifo u_fifo (
    .clk       (clk),
    .rst_n     (rst_n),
    .log_in    (log_in),
    .pop       (pop),
    .log_data  (log_data),
    .log_empty (log_empty),
    .log_full  (log_full)
  );

  uart_tx u_tx (
    .clk       (clk),
    .rst_n     (rst_n),
    .log_empty (log_empty),
    .log_data  (log_data),
    .pop       (pop),
    .tx        (tx)
  );

endmodule

// ==== cpu_top_checker.sv ====
`timescale 1ns/10ps

module cpu_top_checker import cpu_pkg::*, uart_pkg::*; (
  input logic      clk,
  input logic      rst_n,
  input logic      tx,
  input tx_state_e tx_state,
  input log_byte_t log_in,
  input logic      log_full,
  input logic      pop,
  input logic      log_empty,
  input ram_wr_t   core_wr,
  input ram_wr_t   load
);

  a_tx_idle_high: assert property (@(posedge clk) disable iff (!rst_n)
    (tx_state == TX_IDLE) |-> tx)
    else $error("tx low while the transmitter is idle");

  a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n)
    !(log_in.push && log_full))
    else $error("core pushed into a full log buffer");

  a_no_pop_empty: assert property (@(posedge clk) disable iff (!rst_n)
    !(pop && log_empty))
    else $error("transmitter popped an empty log buffer");

  // loader and core share one ram write port
  a_one_writer: assert property (@(posedge clk) disable iff (!rst_n)
    !(core_wr.en && load.en))
    else $error("core write and program load in the same cycle");

endmodule

bind cpu_top cpu_top_checker u_checker (
  .clk       (clk),
  .rst_n     (rst_n),
  .tx        (tx),
  .tx_state  (u_tx.state),
  .log_in    (log_in),
  .log_full  (log_full),
  .pop       (pop),
  .log_empty (log_empty),
  .core_wr   (core_wr),
  .load      (load)
);

// ==== tb_cpu_top.sv ====
`timescale 1ns/10ps
`include "soc_config.svh"

module tb_cpu_top import cpu_pkg::*; ();

  logic    clk;
  logic    rst_n;
  logic    run;
  ram_wr_t load;
  logic    tx;

  logic [`RAM_AW-1:0] prog_addr [$];
  logic [15:0]        prog_data [$];
  logic [7:0]         exp_bytes [$];
  int                 rx_count;
  int                 cycles;
  int                 cycle_limit;
  integer             seed;

  cpu_top u_dut (
    .clk   (clk),
    .rst_n (rst_n),
    .run   (run),
    .load  (load),
    .tx    (tx)
  );

  always #4 clk = ~clk;  // 8 ns period

  task automatic check_value(input string name, input logic [15:0] got,
                             input logic [15:0] exp);
    if (got !== exp) begin
      $display("FAILED %s got=%h exp=%h", name, got, exp);
      $display("test failed");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  // P lines carry program words, E lines the expected log bytes
  task automatic read_trace();
    int          fd;
    string       line;
    logic [15:0] a;
    logic [15:0] d;
    fd = $fopen("cpu_trace.txt", "r");
    if (fd == 0) begin
      $display("could not open the trace file cpu_trace.txt");
      $display("test failed");
      $fatal(1, "no trace file");
    end
    while (!$feof(fd)) begin
      if ($fgets(line, fd) != 0) begin
        if ($sscanf(line, "P %h %h", a, d) == 2) begin
          prog_addr.push_back(a[`RAM_AW-1:0]);
          prog_data.push_back(d);
        end else if ($sscanf(line, "E %h", d) == 1) begin
          exp_bytes.push_back(d[7:0]);
        end
      end
    end
    $fclose(fd);
  endtask

  // entered at the first falling edge that sees the start bit
  task automatic receive_byte(output logic [7:0] data);
    int i;
    repeat (`CLK_PER_BIT / 2 - 1) @(negedge clk);  // middle of start bit
    check_value("tx_start_bit", 16'(tx), 16'h0000);
    for (i = 0; i < 8; i++) begin
      repeat (`CLK_PER_BIT) @(negedge clk);
      data[i] = tx;  // lsb first
    end
    repeat (`CLK_PER_BIT) @(negedge clk);
    check_value("tx_stop_bit", 16'(tx), 16'h0001);
  endtask

  // serial line receiver
  initial begin
    logic [7:0] rx_data;
    rx_count = 0;
    @(posedge rst_n);
    forever begin
      @(negedge clk);
      if (tx === 1'b0) begin
        receive_byte(rx_data);
        if (rx_count < exp_bytes.size()) begin
          check_value("rx_byte", 16'(rx_data), 16'(exp_bytes[rx_count]));
        end
        rx_count++;
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > cycle_limit) begin
      $display("timeout after %0d cycles with %0d of %0d bytes received",
               cycles, rx_count, exp_bytes.size());
      $display("test failed");
      $fatal(1, "timeout");
    end
  end

  initial begin
    int gap;
    clk   = 1'b0;
    rst_n = 1'b0;
    run   = 1'b0;
    load  = '0;
    seed  = 32'h4c7bd67d;
    cycles      = 0;
    cycle_limit = 1000;
    read_trace();
    if (exp_bytes.size() == 0) begin
      $display("the trace file lists no expected bytes");
      $display("test failed");
      $fatal(1, "empty trace");
    end
    cycle_limit = (prog_data.size() + 20) + exp_bytes.size() * (10 * `CLK_PER_BIT + 10);
    repeat (8) @(negedge clk);
    rst_n = 1'b1;
    foreach (prog_data[i]) begin  // one word per cycle, run still low
      @(negedge clk);
      check_value("tx_idle", 16'(tx), 16'h0001);
      load.en   = 1'b1;
      load.addr = prog_addr[i];
      load.data = prog_data[i];
    end
    @(negedge clk);
    load = '0;
    gap  = $unsigned($random(seed)) % 16;
    repeat (gap) begin
      @(negedge clk);
      check_value("tx_idle", 16'(tx), 16'h0001);
    end
    run = 1'b1;
    wait (rx_count == exp_bytes.size());
    $display("test passed");
    $finish;
  end

endmodule

// ==== cpu_trace.txt ====
# P <word address> <program word>, both hex, loaded before run
# E <expected log byte>, hex, in arrival order on the serial line
P 00 0401  # num2reg r1
P 01 0041
P 02 0301  # reg2ram r1 -> 50
P 03 0032
P 04 0202  # ram2reg 50 -> r2
P 05 0032
P 06 0F02  # out r2
P 07 0000
P 08 0700  # unknown opcode
P 09 0000
P 0A 0403  # num2reg r3
P 0B 0062
P 0C 0F03  # out r3, loop start
P 0D 0000
P 0E 0F02  # out r2
P 0F 0000
P 10 0100  # jmp 12
P 11 000C
E 53
E 34
E 33
E 32
E 41
E 78
E 34
E 62
E 41
E 31
E 62
E 41
E 31
E 62
E 41
E 31
E 62
E 41
E 31
E 62
E 41
E 31
E 62
E 41

// ==== sources.f ====
+incdir+.
cpu_pkg.sv
uart_pkg.sv
program_ram.sv
cpu_core.sv
log_fifo.sv
uart_tx.sv
cpu_top.sv
cpu_top_checker.sv
tb_cpu_top.sv

// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing --assert
TOP       := tb_cpu_top
FILELIST  := sources.f
BUILD_DIR := obj_dir
LOG       := sim.log

SOURCES   := $(filter-out +%,$(shell cat $(FILELIST))) soc_config.svh
SIM_BIN   := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	$(SIM_BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "test failed" $(LOG) || ! grep -q "test passed" $(LOG); then \
		echo "simulation reported failure"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
